/* verilog.f */
+incdir+include
hdl/beam_sort_pkg.sv
hdl/beam_rank.sv
hdl/index_mem_arbiter.sv
hdl/beam_readout.sv
hdl/beam_sort_top.sv
tests/beam_sort_chk.sv
tests/beam_sort_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module beam_sort_tb -o beam_sort_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/beam_sort_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi
exit 0

/* tests/beam_sort_tb.sv */
`timescale 1ns/1ps
`include "beam_sort_consts.svh"

module beam_sort_tb;

    localparam int N_TESTS     = 5;
    localparam int TEST_CYCLES = 200;

    logic                       i_clk = 1'b0;
    logic                       i_reset;
    logic                       i_req;
    beam_sort_pkg::data_vec_t   i_data;
    logic                       o_ack;
    beam_sort_pkg::score_vec_t  o_score;
    beam_sort_pkg::data_vec_t   o_sorted_data;
    beam_sort_pkg::rbg_addr_t   o_rbg_num;
    logic                       i_bid_rden;
    beam_sort_pkg::rbg_addr_t   i_rbg_max;
    beam_sort_pkg::index_word_t o_beam_index;
    logic                       o_tvalid;

    // Reference state, what the index memory should hold
    beam_sort_pkg::index_word_t model_mem [`RBG_DEPTH];
    beam_sort_pkg::rbg_addr_t   model_slot = '0;
    int                         read_ptr = 0;

    beam_sort_top i_dut (.*);

    bind beam_sort_top beam_sort_chk u_chk (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_req    (i_req),
        .i_ack    (o_ack),
        .i_tvalid (o_tvalid),
        .i_wr_req (wr_req),
        .i_wr_ack (wr_ack),
        .i_rd_ack (rd_ack)
    );

    always #50 i_clk = ~i_clk;

    initial begin
        repeat (N_TESTS * TEST_CYCLES + 5) @(posedge i_clk);
        $display("Timeout: the tests did not finish within their cycle budget");
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------
    task automatic stop_with_error(input string msg);
        $display("** Error at %0t: %s", $time, msg);
        $display(">>> FAIL");
        $fatal(1, "mismatch");
    endtask

    task automatic check_scores(input beam_sort_pkg::score_vec_t got,
                                input beam_sort_pkg::score_vec_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("scores %h, expected %h", got, exp));
        end
    endtask

    task automatic check_data(input beam_sort_pkg::data_vec_t got,
                              input beam_sort_pkg::data_vec_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("sorted data %h, expected %h", got, exp));
        end
    endtask

    task automatic check_word(input beam_sort_pkg::index_word_t got,
                              input beam_sort_pkg::index_word_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("beam index word %h, expected %h", got, exp));
        end
    endtask

    task automatic check_slot(input beam_sort_pkg::rbg_addr_t got,
                              input beam_sort_pkg::rbg_addr_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("o_rbg_num %0d, expected %0d", got, exp));
        end
    endtask

    // ------------------------------------------------------------------------
    // Frame and readout drivers with the reference model
    // ------------------------------------------------------------------------
    task automatic run_frame(input beam_sort_pkg::data_vec_t d);
        beam_sort_pkg::score_vec_t  exp_score;
        beam_sort_pkg::data_vec_t   exp_data;
        beam_sort_pkg::index_word_t exp_word;
        bit                         used [`BEAM_COUNT];
        int                         n;
        int                         best;
        // Score is the count of beams ranked ahead under the rule
        for (int i = 0; i < `BEAM_COUNT; i++) begin
            n = 0;
            for (int j = 0; j < `BEAM_COUNT; j++) begin
                if ((d[j] > d[i]) || ((d[j] == d[i]) && (j < i))) begin
                    n++;
                end
            end
            exp_score[i] = beam_sort_pkg::beam_idx_t'(n);
            used[i] = 1'b0;
        end
        // Pick the strongest remaining beam, lowest index first on a tie
        for (int k = 0; k < `BEAM_COUNT; k++) begin
            best = -1;
            for (int j = 0; j < `BEAM_COUNT; j++) begin
                if (!used[j] && ((best < 0) || (d[j] > d[best]))) begin
                    best = j;
                end
            end
            used[best] = 1'b1;
            exp_data[k] = d[best];
            if (k < `TOP_BEAMS) begin
                exp_word[k] = beam_sort_pkg::beam_idx_t'(best);
            end
        end
        check_slot(o_rbg_num, model_slot);
        model_mem[model_slot] = exp_word;
        model_slot = beam_sort_pkg::rbg_addr_t'((int'(model_slot) + 1) % `RBG_DEPTH);
        @(posedge i_clk);
        i_req  <= 1'b1;
        i_data <= d;
        do @(negedge i_clk); while (!o_ack);
        check_scores(o_score, exp_score);
        check_data(o_sorted_data, exp_data);
        check_slot(o_rbg_num, model_slot);
        @(posedge i_clk);
        i_req <= 1'b0;
        do @(negedge i_clk); while (o_ack);
    endtask

    task automatic read_slot();
        beam_sort_pkg::index_word_t exp_word;
        exp_word = model_mem[read_ptr];
        @(posedge i_clk);
        i_bid_rden <= 1'b1;
        @(posedge i_clk);
        i_bid_rden <= 1'b0;
        do @(negedge i_clk); while (!o_tvalid);
        check_word(o_beam_index, exp_word);
        read_ptr = (read_ptr == int'(i_rbg_max)) ? 0 : read_ptr + 1;
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------
    task automatic reset_state_is_idle();
        @(negedge i_clk);
        if (o_ack !== 1'b0 || o_tvalid !== 1'b0) begin
            stop_with_error("o_ack or o_tvalid high after reset");
        end
        check_slot(o_rbg_num, '0);
    endtask

    task automatic rank_distinct_frames();
        beam_sort_pkg::data_vec_t d;
        for (int f = 0; f < 3; f++) begin
            // Low nibble holds the beam index, so values never repeat
            for (int i = 0; i < `BEAM_COUNT; i++) begin
                d[i] = beam_sort_pkg::beam_data_t'(($urandom & 32'hfff0) | i);
            end
            run_frame(d);
        end
    endtask

    task automatic rank_tied_values();
        beam_sort_pkg::data_vec_t d;
        for (int i = 0; i < `BEAM_COUNT; i++) begin
            d[i] = beam_sort_pkg::beam_data_t'(($urandom % 3) * 256);
        end
        run_frame(d);
    endtask

    task automatic read_slots_with_wrap();
        beam_sort_pkg::data_vec_t d;
        // Fill the rest of the memory
        for (int f = 0; f < 4; f++) begin
            for (int i = 0; i < `BEAM_COUNT; i++) begin
                d[i] = beam_sort_pkg::beam_data_t'($urandom);
            end
            run_frame(d);
        end
        @(posedge i_clk);
        i_rbg_max <= beam_sort_pkg::rbg_addr_t'(5);
        for (int r = 0; r < 9; r++) begin
            read_slot();
        end
    endtask

    task automatic read_during_scoring();
        beam_sort_pkg::data_vec_t d;
        for (int i = 0; i < `BEAM_COUNT; i++) begin
            d[i] = beam_sort_pkg::beam_data_t'($urandom);
        end
        fork
            run_frame(d);
            begin
                repeat (4) @(posedge i_clk);
                read_slot();
            end
        join
    endtask

    initial begin
        void'($urandom(32'h99a6ecf3));
        i_reset    = 1'b1;
        i_req      = 1'b0;
        i_data     = '0;
        i_bid_rden = 1'b0;
        i_rbg_max  = '0;
        repeat (5) @(posedge i_clk);
        i_reset <= 1'b0;
        reset_state_is_idle();
        rank_distinct_frames();
        rank_tied_values();
        read_slots_with_wrap();
        read_during_scoring();
        $display(">>> PASS");
        $finish;
    end

endmodule

/* tests/beam_sort_chk.sv */
`timescale 1ns/1ps

module beam_sort_chk (
    input logic i_clk,
    input logic i_reset,
    input logic i_req,
    input logic i_ack,
    input logic i_tvalid,
    input logic i_wr_req,
    input logic i_wr_ack,
    input logic i_rd_ack
);

    // Frame ack only answers a pending request
    ack_needs_req: assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(i_ack) |-> i_req) else $error("o_ack rose without i_req");

    tvalid_one_cycle: assert property (@(posedge i_clk) disable iff (i_reset)
        i_tvalid |=> !i_tvalid) else $error("o_tvalid held longer than one cycle");

    // Arbiter grants one port at a time
    acks_exclusive: assert property (@(posedge i_clk) disable iff (i_reset)
        !(i_wr_ack && i_rd_ack)) else $error("wr_ack and rd_ack both high");

    wr_req_held: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_wr_req && !i_wr_ack) |=> i_wr_req) else $error("wr_req fell before wr_ack");

endmodule

/* hdl/beam_sort_top.sv */
`timescale 1ns/1ps

module beam_sort_top (
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  logic                       i_req,
    input  beam_sort_pkg::data_vec_t   i_data,
    output logic                       o_ack,
    output beam_sort_pkg::score_vec_t  o_score,
    output beam_sort_pkg::data_vec_t   o_sorted_data,
    output beam_sort_pkg::rbg_addr_t   o_rbg_num,
    input  logic                       i_bid_rden,
    input  beam_sort_pkg::rbg_addr_t   i_rbg_max,
    output beam_sort_pkg::index_word_t o_beam_index,
    output logic                       o_tvalid
);

    // Writer side of the index memory
    logic                       wr_req;
    logic                       wr_ack;
    beam_sort_pkg::rbg_addr_t   wr_addr;
    beam_sort_pkg::index_word_t wr_word;

    // Reader side
    logic                       rd_req;
    logic                       rd_ack;
    beam_sort_pkg::rbg_addr_t   rd_addr;
    beam_sort_pkg::index_word_t rd_word;

    beam_rank u_beam_rank (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_req         (i_req),
        .i_data        (i_data),
        .o_ack         (o_ack),
        .o_score       (o_score),
        .o_sorted_data (o_sorted_data),
        .o_rbg_num     (o_rbg_num),
        .o_wr_req      (wr_req),
        .o_wr_addr     (wr_addr),
        .o_wr_word     (wr_word),
        .i_wr_ack      (wr_ack)
    );

    index_mem_arbiter u_index_mem_arbiter (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_wr_req  (wr_req),
        .i_wr_addr (wr_addr),
        .i_wr_word (wr_word),
        .o_wr_ack  (wr_ack),
        .i_rd_req  (rd_req),
        .i_rd_addr (rd_addr),
        .o_rd_word (rd_word),
        .o_rd_ack  (rd_ack)
    );

    beam_readout u_beam_readout (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_bid_rden   (i_bid_rden),
        .i_rbg_max    (i_rbg_max),
        .o_rd_req     (rd_req),
        .o_rd_addr    (rd_addr),
        .i_rd_word    (rd_word),
        .i_rd_ack     (rd_ack),
        .o_beam_index (o_beam_index),
        .o_tvalid     (o_tvalid)
    );

endmodule

/* hdl/beam_readout.sv */
`timescale 1ns/1ps

module beam_readout (
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  logic                       i_bid_rden,
    input  beam_sort_pkg::rbg_addr_t   i_rbg_max,
    output logic                       o_rd_req,
    output beam_sort_pkg::rbg_addr_t   o_rd_addr,
    input  beam_sort_pkg::index_word_t i_rd_word,
    input  logic                       i_rd_ack,
    output beam_sort_pkg::index_word_t o_beam_index,
    output logic                       o_tvalid
);

    beam_sort_pkg::rbg_addr_t rd_ptr;

    // ------------------------------------------------------------------------
    // Read request, delivery and pointer
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_rd_req <= 1'b0;
            o_tvalid <= 1'b0;
            rd_ptr   <= '0;
        end else begin
            o_tvalid <= 1'b0;
            if (!o_rd_req) begin
                // Pulses are dropped until the previous ack has fallen
                if (i_bid_rden && !i_rd_ack) begin
                    o_rd_req <= 1'b1;
                end
            end else if (i_rd_ack) begin
                o_rd_req <= 1'b0;
                o_tvalid <= 1'b1;
                // Wrap after the last slot in use
                rd_ptr   <= (rd_ptr == i_rbg_max) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // Returned word
    always_ff @(posedge i_clk) begin
        if (o_rd_req && i_rd_ack) begin
            o_beam_index <= i_rd_word;
        end
    end

    assign o_rd_addr = rd_ptr;

endmodule

/* hdl/index_mem_arbiter.sv */
`timescale 1ns/1ps
`include "beam_sort_consts.svh"

module index_mem_arbiter (
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  logic                       i_wr_req,
    input  beam_sort_pkg::rbg_addr_t   i_wr_addr,
    input  beam_sort_pkg::index_word_t i_wr_word,
    output logic                       o_wr_ack,
    input  logic                       i_rd_req,
    input  beam_sort_pkg::rbg_addr_t   i_rd_addr,
    output beam_sort_pkg::index_word_t o_rd_word,
    output logic                       o_rd_ack
);

    localparam logic [1:0] GNT_IDLE  = 2'd0;
    localparam logic [1:0] GNT_WRITE = 2'd1;
    localparam logic [1:0] GNT_READ  = 2'd2;

    logic [1:0]                 grant;
    logic                       wr_grant;
    logic                       rd_grant;
    beam_sort_pkg::index_word_t mem [`RBG_DEPTH];

    // Writer wins a tie
    assign wr_grant = (grant == GNT_IDLE) && i_wr_req;
    assign rd_grant = (grant == GNT_IDLE) && !i_wr_req && i_rd_req;

    // ------------------------------------------------------------------------
    // Grant state and acks
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            grant    <= GNT_IDLE;
            o_wr_ack <= 1'b0;
            o_rd_ack <= 1'b0;
        end else begin
            case (grant)
                GNT_IDLE: begin
                    if (wr_grant) begin
                        o_wr_ack <= 1'b1;
                        grant    <= GNT_WRITE;
                    end else if (rd_grant) begin
                        o_rd_ack <= 1'b1;
                        grant    <= GNT_READ;
                    end
                end
                // Ack held until the requester lets go
                GNT_WRITE: begin
                    if (!i_wr_req) begin
                        o_wr_ack <= 1'b0;
                        grant    <= GNT_IDLE;
                    end
                end
                GNT_READ: begin
                    if (!i_rd_req) begin
                        o_rd_ack <= 1'b0;
                        grant    <= GNT_IDLE;
                    end
                end
                default: begin
                    grant <= GNT_IDLE;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Storage, accessed in the grant cycle
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (wr_grant) begin
            mem[i_wr_addr] <= i_wr_word;
        end
        if (rd_grant) begin
            o_rd_word <= mem[i_rd_addr];
        end
    end

endmodule

/* hdl/beam_rank.sv */
`timescale 1ns/1ps
`include "beam_sort_consts.svh"

module beam_rank (
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  logic                       i_req,
    input  beam_sort_pkg::data_vec_t   i_data,
    output logic                       o_ack,
    output beam_sort_pkg::score_vec_t  o_score,
    output beam_sort_pkg::data_vec_t   o_sorted_data,
    output beam_sort_pkg::rbg_addr_t   o_rbg_num,
    output logic                       o_wr_req,
    output beam_sort_pkg::rbg_addr_t   o_wr_addr,
    output beam_sort_pkg::index_word_t o_wr_word,
    input  logic                       i_wr_ack
);

    localparam logic [2:0] ST_IDLE  = 3'd0;
    localparam logic [2:0] ST_SCORE = 3'd1;
    localparam logic [2:0] ST_SORT  = 3'd2;
    localparam logic [2:0] ST_WRITE = 3'd3;
    localparam logic [2:0] ST_ACK   = 3'd4;

    localparam beam_sort_pkg::beam_idx_t LAST_BEAM = beam_sort_pkg::beam_idx_t'(`BEAM_COUNT - 1);
    localparam beam_sort_pkg::beam_idx_t IDX_ONE   = beam_sort_pkg::beam_idx_t'(1);
    localparam beam_sort_pkg::rbg_addr_t LAST_SLOT = beam_sort_pkg::rbg_addr_t'(`RBG_DEPTH - 1);

    logic [2:0]                 state;
    beam_sort_pkg::beam_idx_t   cnt;
    beam_sort_pkg::rbg_addr_t   rbg_num;
    beam_sort_pkg::data_vec_t   data_q;
    beam_sort_pkg::score_vec_t  score_q;
    beam_sort_pkg::data_vec_t   sorted_data;
    beam_sort_pkg::score_vec_t  sorted_idx;
    beam_sort_pkg::beam_data_t  cur_data;
    beam_sort_pkg::beam_idx_t   cur_score;

    // ------------------------------------------------------------------------
    // Comparator row, scores beam cnt against the captured frame
    // ------------------------------------------------------------------------
    always_comb begin
        cur_data  = data_q[cnt];
        cur_score = '0;
        for (int j = 0; j < `BEAM_COUNT; j++) begin
            // Larger value wins, ties go to the lower index
            if ((data_q[j] > cur_data) || ((data_q[j] == cur_data) && (j < int'(cnt)))) begin
                cur_score = cur_score + IDX_ONE;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Control FSM and frame handshake
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state    <= ST_IDLE;
            cnt      <= '0;
            rbg_num  <= '0;
            o_ack    <= 1'b0;
            o_wr_req <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_req) begin
                        cnt   <= '0;
                        state <= ST_SCORE;
                    end
                end
                ST_SCORE: begin
                    cnt <= cnt + IDX_ONE;
                    if (cnt == LAST_BEAM) begin
                        state <= ST_SORT;
                    end
                end
                ST_SORT: begin
                    o_wr_req <= 1'b1;
                    state    <= ST_WRITE;
                end
                ST_WRITE: begin
                    if (i_wr_ack) begin
                        o_wr_req <= 1'b0;
                        o_ack    <= 1'b1;
                        // Slot for the next frame
                        rbg_num  <= (rbg_num == LAST_SLOT) ? '0 : rbg_num + 1'b1;
                        state    <= ST_ACK;
                    end
                end
                ST_ACK: begin
                    if (!i_req) begin
                        o_ack <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Frame capture, score store and scatter into rank order
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if ((state == ST_IDLE) && i_req) begin
            data_q <= i_data;
        end
        if (state == ST_SCORE) begin
            score_q[cnt] <= cur_score;
        end
        // Scores are a permutation, so every slot is written once
        if (state == ST_SORT) begin
            for (int i = 0; i < `BEAM_COUNT; i++) begin
                sorted_data[score_q[i]] <= data_q[i];
                sorted_idx[score_q[i]]  <= beam_sort_pkg::beam_idx_t'(i);
            end
        end
    end

    assign o_score       = score_q;
    assign o_sorted_data = sorted_data;
    assign o_rbg_num     = rbg_num;
    assign o_wr_addr     = rbg_num;
    assign o_wr_word     = sorted_idx[`TOP_BEAMS-1:0];

endmodule

/* hdl/beam_sort_pkg.sv */
`include "beam_sort_consts.svh"

package beam_sort_pkg;

    // One beam power value
    typedef logic [`DATA_W-1:0] beam_data_t;

    // A beam index and a score share the same width
    typedef logic [`BEAM_IDX_W-1:0] beam_idx_t;

    // Slot address in the index memory
    typedef logic [`RBG_W-1:0] rbg_addr_t;

    // Whole frame, element 0 is beam 0
    typedef beam_data_t [`BEAM_COUNT-1:0] data_vec_t;

    // One score per beam, or beam indices in score order
    typedef beam_idx_t [`BEAM_COUNT-1:0] score_vec_t;

    // Memory word, element 0 holds the strongest beam
    typedef beam_idx_t [`TOP_BEAMS-1:0] index_word_t;

endpackage

/* include/beam_sort_consts.svh */
`ifndef BEAM_SORT_CONSTS_SVH
`define BEAM_SORT_CONSTS_SVH

// Frame geometry
`define BEAM_COUNT 16
`define BEAM_IDX_W 4
`define DATA_W     16

// Indices kept per RBG slot
`define TOP_BEAMS  4

// Index memory
`define RBG_DEPTH  8
`define RBG_W      3

`endif
